//--- src/procPkg.sv
package procPkg;

    // Widths fixed by the instruction set
    typedef logic [31:0] word_t;      // Data, instruction or address word
    typedef logic [4:0]  regAddr_t;   // Register index
    typedef logic [4:0]  opcode_t;    // Bits 31..27
    typedef logic [4:0]  aluOp_t;     // Bits 6..2, R-type only
    typedef logic [1:0]  bypassSel_t; // Operand source in execute

    localparam opcode_t OP_RTYPE = 5'b00000;
    localparam opcode_t OP_ADDI  = 5'b00101;
    localparam opcode_t OP_SW    = 5'b00111;
    localparam opcode_t OP_LW    = 5'b01000;

    localparam aluOp_t ALU_ADD = 5'b00000;
    localparam aluOp_t ALU_SUB = 5'b00001;
    localparam aluOp_t ALU_AND = 5'b00010;
    localparam aluOp_t ALU_OR  = 5'b00011;
    localparam aluOp_t ALU_SLL = 5'b00100;
    localparam aluOp_t ALU_SRA = 5'b00101;

    // Bypass sources for execute operands
    localparam bypassSel_t BYP_LATCH     = 2'd0; // Value read in decode
    localparam bypassSel_t BYP_MEMORY    = 2'd1; // Result one instruction back
    localparam bypassSel_t BYP_WRITEBACK = 2'd2; // Result two instructions back

    function automatic opcode_t opcodeOf(word_t ir);
        return ir[31:27];
    endfunction

    function automatic regAddr_t rdOf(word_t ir);
        return ir[26:22];
    endfunction

    function automatic regAddr_t rsOf(word_t ir);
        return ir[21:17];
    endfunction

    function automatic regAddr_t rtOf(word_t ir);
        return ir[16:12];
    endfunction

    function automatic aluOp_t aluOpOf(word_t ir);
        return ir[6:2];
    endfunction

    function automatic word_t immOf(word_t ir);
        return {{15{ir[16]}}, ir[16:0]}; // Sign-extend 17 bits
    endfunction

    function automatic logic writesReg(word_t ir);
        opcode_t op;
        op = opcodeOf(ir);
        return (op == OP_RTYPE || op == OP_ADDI || op == OP_LW) && rdOf(ir) != 5'd0;
    endfunction

    // Second source register: rd holds the store data for sw
    function automatic regAddr_t srcBOf(word_t ir);
        return (opcodeOf(ir) == OP_SW) ? rdOf(ir) : rtOf(ir);
    endfunction

    function automatic logic readsSrcA(word_t ir);
        opcode_t op;
        op = opcodeOf(ir);
        return op == OP_RTYPE || op == OP_ADDI || op == OP_LW || op == OP_SW;
    endfunction

    function automatic logic readsSrcB(word_t ir);
        return opcodeOf(ir) == OP_RTYPE || opcodeOf(ir) == OP_SW;
    endfunction

endpackage

//--- src/instrMem.sv
`timescale 1ns/1ps

module instrMem #(
    parameter int MEM_DEPTH_LOG2 = 10
) (
    input  logic          clock,
    input  logic          progWrite,  // Load port, used while reset is held
    input  procPkg::word_t progAddr,
    input  procPkg::word_t progData,
    input  procPkg::word_t pc,
    output procPkg::word_t instr
);

    procPkg::word_t mem [2**MEM_DEPTH_LOG2];

    // Unloaded words decode as add r0,r0,r0
    initial begin
        for (int i = 0; i < 2**MEM_DEPTH_LOG2; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clock) begin
        if (progWrite) begin
            mem[progAddr[MEM_DEPTH_LOG2-1:0]] <= progData;
        end
    end

    assign instr = mem[pc[MEM_DEPTH_LOG2-1:0]]; // Fetch read, no latency

endmodule

//--- src/fetchStage.sv
`timescale 1ns/1ps

module fetchStage (
    input  logic           clock,
    input  logic           reset,
    input  logic           stall,    // Load-use interlock
    input  procPkg::word_t instr,    // From instruction memory
    output procPkg::word_t pc,
    output procPkg::word_t decodeIr
);

    procPkg::word_t pcNext;

    // No branches, so always the next word
    assign pcNext = pc + 32'd1;

    // Program counter
    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
        end else if (!stall) begin
            pc <= pcNext;
        end
    end

    // Fetch/decode latch
    // Holds with the PC so the stalled instruction is decoded again
    always_ff @(posedge clock) begin
        if (reset) begin
            decodeIr <= '0;
        end else if (!stall) begin
            decodeIr <= instr;
        end
    end

endmodule

//--- src/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic              clock,
    input  logic              reset,
    input  logic              writeEnable,
    input  procPkg::regAddr_t writeAddr,
    input  procPkg::word_t    writeData,
    input  procPkg::regAddr_t readAddrA,
    input  procPkg::regAddr_t readAddrB,
    output procPkg::word_t    readDataA,
    output procPkg::word_t    readDataB
);

    procPkg::word_t regs [32];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddr != 5'd0) begin // r0 stays zero
            regs[writeAddr] <= writeData;
        end
    end

    // Write-through, covers a producer three instructions back
    assign readDataA = (readAddrA == 5'd0) ? '0 :
                       (writeEnable && writeAddr == readAddrA) ? writeData : regs[readAddrA];
    assign readDataB = (readAddrB == 5'd0) ? '0 :
                       (writeEnable && writeAddr == readAddrB) ? writeData : regs[readAddrB];

endmodule

//--- src/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
    input  procPkg::word_t     decodeIr,
    input  procPkg::word_t     executeIr,
    input  procPkg::word_t     memoryIr,
    input  procPkg::word_t     writebackIr,
    output logic               stall,
    output procPkg::bypassSel_t aluASel,
    output procPkg::bypassSel_t aluBSel,
    output procPkg::bypassSel_t storeSel
);

    logic loadInExecute;
    logic matchA;
    logic matchB;

    // Newest producer wins
    function automatic procPkg::bypassSel_t pickSource(procPkg::regAddr_t src,
                                                       procPkg::word_t    memIr,
                                                       procPkg::word_t    wbIr);
        if (src == 5'd0) begin
            return procPkg::BYP_LATCH; // r0 never forwarded
        end
        if (procPkg::writesReg(memIr) && procPkg::rdOf(memIr) == src) begin
            return procPkg::BYP_MEMORY;
        end
        if (procPkg::writesReg(wbIr) && procPkg::rdOf(wbIr) == src) begin
            return procPkg::BYP_WRITEBACK;
        end
        return procPkg::BYP_LATCH;
    endfunction

    // Load data exists only after the memory stage so one bubble is needed
    assign loadInExecute = procPkg::opcodeOf(executeIr) == procPkg::OP_LW
                           && procPkg::writesReg(executeIr);
    assign matchA = procPkg::readsSrcA(decodeIr)
                    && procPkg::rsOf(decodeIr) == procPkg::rdOf(executeIr);
    assign matchB = procPkg::readsSrcB(decodeIr)
                    && procPkg::srcBOf(decodeIr) == procPkg::rdOf(executeIr);
    assign stall = loadInExecute && (matchA || matchB);

    assign aluASel = procPkg::readsSrcA(executeIr) ?
                     pickSource(procPkg::rsOf(executeIr), memoryIr, writebackIr) :
                     procPkg::BYP_LATCH;

    // Only R-type takes a register as ALU B; others use the immediate
    assign aluBSel = (procPkg::opcodeOf(executeIr) == procPkg::OP_RTYPE) ?
                     pickSource(procPkg::rtOf(executeIr), memoryIr, writebackIr) :
                     procPkg::BYP_LATCH;

    // Store data comes from rd
    assign storeSel = (procPkg::opcodeOf(executeIr) == procPkg::OP_SW) ?
                      pickSource(procPkg::rdOf(executeIr), memoryIr, writebackIr) :
                      procPkg::BYP_LATCH;

endmodule

//--- src/decodeExecute.sv
`timescale 1ns/1ps

module decodeExecute (
    input  logic                clock,
    input  logic                reset,
    input  procPkg::word_t      decodeIr,
    input  logic                bubble,         // Zero instruction into execute
    input  procPkg::word_t      readDataA,
    input  procPkg::word_t      readDataB,
    input  procPkg::bypassSel_t aluASel,
    input  procPkg::bypassSel_t aluBSel,
    input  procPkg::bypassSel_t storeSel,
    input  procPkg::word_t      memoryResultIn, // Looped back from memoryResult
    input  procPkg::word_t      writebackData,
    output procPkg::regAddr_t   readAddrA,
    output procPkg::regAddr_t   readAddrB,
    output procPkg::word_t      executeIr,
    output procPkg::word_t      memoryIr,
    output procPkg::word_t      memoryResult,
    output procPkg::word_t      memoryStoreData
);

    procPkg::word_t executeA;    // Operands as read in decode
    procPkg::word_t executeB;
    procPkg::word_t aluA;
    procPkg::word_t regB;        // Forwarded rt
    procPkg::word_t aluB;
    procPkg::word_t storeData;   // Forwarded rd of sw
    procPkg::word_t aluOut;
    procPkg::aluOp_t aluOp;
    logic [4:0] shamt;

    function automatic procPkg::word_t bypassMux(procPkg::bypassSel_t sel,
                                                 procPkg::word_t      latched,
                                                 procPkg::word_t      fromMemory,
                                                 procPkg::word_t      fromWriteback);
        case (sel)
            procPkg::BYP_MEMORY:    return fromMemory;
            procPkg::BYP_WRITEBACK: return fromWriteback;
            default:                return latched;
        endcase
    endfunction

    // Decode reads rs always, rt or rd as second source
    assign readAddrA = procPkg::rsOf(decodeIr);
    assign readAddrB = procPkg::srcBOf(decodeIr);

    // Decode/execute latch
    always_ff @(posedge clock) begin
        if (reset) begin
            executeIr <= '0;
            executeA  <= '0;
            executeB  <= '0;
        end else begin
            executeIr <= bubble ? '0 : decodeIr; // Bubble is add r0,r0,r0
            executeA  <= readDataA;
            executeB  <= readDataB;
        end
    end

    assign aluA      = bypassMux(aluASel, executeA, memoryResultIn, writebackData);
    assign regB      = bypassMux(aluBSel, executeB, memoryResultIn, writebackData);
    assign storeData = bypassMux(storeSel, executeB, memoryResultIn, writebackData);

    // Immediate for addi, lw and sw address
    assign aluB  = (procPkg::opcodeOf(executeIr) == procPkg::OP_RTYPE) ?
                   regB : procPkg::immOf(executeIr);
    assign aluOp = (procPkg::opcodeOf(executeIr) == procPkg::OP_RTYPE) ?
                   procPkg::aluOpOf(executeIr) : procPkg::ALU_ADD;
    assign shamt = executeIr[11:7];

    always_comb begin
        case (aluOp)
            procPkg::ALU_ADD: aluOut = aluA + aluB;
            procPkg::ALU_SUB: aluOut = aluA - aluB;
            procPkg::ALU_AND: aluOut = aluA & aluB;
            procPkg::ALU_OR:  aluOut = aluA | aluB;
            procPkg::ALU_SLL: aluOut = aluA << shamt;
            procPkg::ALU_SRA: aluOut = $signed(aluA) >>> shamt; // Keeps the sign
            default:          aluOut = '0;                       // Unused op codes
        endcase
    end

    // Execute/memory latch
    always_ff @(posedge clock) begin
        if (reset) begin
            memoryIr        <= '0;
            memoryResult    <= '0;
            memoryStoreData <= '0;
        end else begin
            memoryIr        <= executeIr;
            memoryResult    <= aluOut;
            memoryStoreData <= storeData;
        end
    end

endmodule

//--- src/dataMem.sv
`timescale 1ns/1ps

module dataMem #(
    parameter int MEM_DEPTH_LOG2 = 10
) (
    input  logic           clock,
    input  logic           memWrite,
    input  procPkg::word_t addr,      // Word address, upper bits ignored
    input  procPkg::word_t writeData,
    output procPkg::word_t readData
);

    procPkg::word_t mem [2**MEM_DEPTH_LOG2];

    initial begin
        for (int i = 0; i < 2**MEM_DEPTH_LOG2; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clock) begin
        if (memWrite) begin
            mem[addr[MEM_DEPTH_LOG2-1:0]] <= writeData;
        end
    end

    assign readData = mem[addr[MEM_DEPTH_LOG2-1:0]]; // Same-cycle load

endmodule

//--- src/memWriteback.sv
`timescale 1ns/1ps

module memWriteback #(
    parameter int MEM_DEPTH_LOG2 = 10
) (
    input  logic              clock,
    input  logic              reset,
    input  procPkg::word_t    memoryIr,
    input  procPkg::word_t    memoryResult,    // ALU result or address
    input  procPkg::word_t    memoryStoreData,
    output logic              memWrite,
    output procPkg::word_t    memAddr,
    output procPkg::word_t    memData,
    output procPkg::word_t    writebackIr,
    output procPkg::word_t    writebackData,
    output logic              regWriteEnable,
    output procPkg::regAddr_t regWriteAddr
);

    procPkg::word_t loadData;
    procPkg::word_t writebackResult;
    procPkg::word_t writebackLoad;

    // Memory stage
    assign memWrite = procPkg::opcodeOf(memoryIr) == procPkg::OP_SW;
    assign memAddr  = memoryResult;
    assign memData  = memoryStoreData;

    dataMem #(
        .MEM_DEPTH_LOG2(MEM_DEPTH_LOG2)
    ) dataMem0 (
        .clock    (clock),
        .memWrite (memWrite),
        .addr     (memAddr),
        .writeData(memData),
        .readData (loadData)
    );

    // Memory/writeback latch
    always_ff @(posedge clock) begin
        if (reset) begin
            writebackIr     <= '0;
            writebackResult <= '0;
            writebackLoad   <= '0;
        end else begin
            writebackIr     <= memoryIr;
            writebackResult <= memoryResult;
            writebackLoad   <= loadData;
        end
    end

    // Load data for lw, ALU result otherwise
    assign writebackData  = (procPkg::opcodeOf(writebackIr) == procPkg::OP_LW) ?
                            writebackLoad : writebackResult;
    assign regWriteEnable = procPkg::writesReg(writebackIr); // Drops r0 and sw
    assign regWriteAddr   = procPkg::rdOf(writebackIr);

endmodule

//--- src/procTop.sv
`timescale 1ns/1ps

module procTop #(
    parameter int MEM_DEPTH_LOG2 = 10 // Address bits of each memory
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              progWrite,
    input  procPkg::word_t    progAddr,
    input  procPkg::word_t    progData,
    output logic              regWriteEnable,
    output procPkg::regAddr_t regWriteAddr,
    output procPkg::word_t    regWriteData,
    output logic              memWrite,
    output procPkg::word_t    memAddr,
    output procPkg::word_t    memData
);

    procPkg::word_t      pc;
    procPkg::word_t      instr;
    procPkg::word_t      decodeIr;
    procPkg::word_t      executeIr;
    procPkg::word_t      memoryIr;
    procPkg::word_t      writebackIr;
    procPkg::word_t      memoryResult;
    procPkg::word_t      memoryStoreData;
    procPkg::word_t      writebackData;
    procPkg::regAddr_t   readAddrA;
    procPkg::regAddr_t   readAddrB;
    procPkg::word_t      readDataA;
    procPkg::word_t      readDataB;
    procPkg::bypassSel_t aluASel;
    procPkg::bypassSel_t aluBSel;
    procPkg::bypassSel_t storeSel;
    logic                stall;      // Also the bubble into execute

    instrMem #(.MEM_DEPTH_LOG2(MEM_DEPTH_LOG2)) instrMem0 (
        .clock(clock), .progWrite(progWrite), .progAddr(progAddr),
        .progData(progData), .pc(pc), .instr(instr)
    );

    fetchStage fetchStage0 (
        .clock(clock), .reset(reset), .stall(stall), .instr(instr),
        .pc(pc), .decodeIr(decodeIr)
    );

    regFile regFile0 (
        .clock(clock), .reset(reset),
        .writeEnable(regWriteEnable), .writeAddr(regWriteAddr), .writeData(writebackData),
        .readAddrA(readAddrA), .readAddrB(readAddrB),
        .readDataA(readDataA), .readDataB(readDataB)
    );

    hazardUnit hazardUnit0 (
        .decodeIr(decodeIr), .executeIr(executeIr), .memoryIr(memoryIr),
        .writebackIr(writebackIr), .stall(stall),
        .aluASel(aluASel), .aluBSel(aluBSel), .storeSel(storeSel)
    );

    decodeExecute decodeExecute0 (
        .clock(clock), .reset(reset), .decodeIr(decodeIr), .bubble(stall),
        .readDataA(readDataA), .readDataB(readDataB),
        .aluASel(aluASel), .aluBSel(aluBSel), .storeSel(storeSel),
        .memoryResultIn(memoryResult), .writebackData(writebackData),
        .readAddrA(readAddrA), .readAddrB(readAddrB),
        .executeIr(executeIr), .memoryIr(memoryIr),
        .memoryResult(memoryResult), .memoryStoreData(memoryStoreData)
    );

    memWriteback #(.MEM_DEPTH_LOG2(MEM_DEPTH_LOG2)) memWriteback0 (
        .clock(clock), .reset(reset), .memoryIr(memoryIr),
        .memoryResult(memoryResult), .memoryStoreData(memoryStoreData),
        .memWrite(memWrite), .memAddr(memAddr), .memData(memData),
        .writebackIr(writebackIr), .writebackData(writebackData),
        .regWriteEnable(regWriteEnable), .regWriteAddr(regWriteAddr)
    );

    assign regWriteData = writebackData; // Observed writeback stream

endmodule

//--- dv/procTb.sv
`timescale 1ns/1ps

module procTb;

    localparam int MEM_LOG2    = 10;
    localparam int TAIL_NOPS   = 8;   // Zero words after each program
    localparam int NUM_TESTS   = 6;
    localparam int INSTR_BOUND = 120; // Instructions over all tests, rounded up
    localparam int RANDOM_LEN  = 40;

    logic           clock;
    logic           reset;
    logic           progWrite;
    procPkg::word_t progAddr;
    procPkg::word_t progData;
    logic              regWriteEnable;
    procPkg::regAddr_t regWriteAddr;
    procPkg::word_t    regWriteData;
    logic              memWrite;
    procPkg::word_t    memAddr;
    procPkg::word_t    memData;

    logic [31:0] prog[$];                          // Program under test
    logic [31:0] expWbAddr[$], expWbData[$], expStAddr[$], expStData[$];
    logic [31:0] obsWbAddr[$], obsWbData[$], obsStAddr[$], obsStData[$];
    logic [31:0] modelRegs [32];
    logic [31:0] modelMem [2**MEM_LOG2];           // Persists like dataMem
    logic [15:0] lfsrState = 16'd10536;
    int testsRun = 0;
    int checks = 0;
    int errors = 0;

    procTop #(.MEM_DEPTH_LOG2(MEM_LOG2)) dut0 (
        .clock(clock), .reset(reset),
        .progWrite(progWrite), .progAddr(progAddr), .progData(progData),
        .regWriteEnable(regWriteEnable), .regWriteAddr(regWriteAddr),
        .regWriteData(regWriteData),
        .memWrite(memWrite), .memAddr(memAddr), .memData(memData)
    );

    always #10 clock = ~clock; // 20 ns period

    // Outputs change on the rising edge, sampled half a cycle later
    always @(negedge clock) begin
        if (regWriteEnable === 1'b1) begin
            obsWbAddr.push_back({27'd0, regWriteAddr});
            obsWbData.push_back(regWriteData);
        end
        if (memWrite === 1'b1) begin
            obsStAddr.push_back(memAddr);
            obsStData.push_back(memData);
        end
    end

    initial begin
        #(INSTR_BOUND * 40 + NUM_TESTS * 800);
        $display("Watchdog expired before the tests finished");
        $display("Simulation FAILED");
        $finish;
    end

    // Galois LFSR, taps 16,14,13,11
    function automatic logic [31:0] randBits(int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
        end
        return value;
    endfunction

    function automatic logic [31:0] encodeR(int aluOp, int rd, int rs, int rt, int sh);
        return {procPkg::OP_RTYPE, rd[4:0], rs[4:0], rt[4:0], sh[4:0], aluOp[4:0], 2'b00};
    endfunction

    function automatic logic [31:0] encodeI(int op, int rd, int rs, int imm);
        return {op[4:0], rd[4:0], rs[4:0], imm[16:0]}; // Immediate truncated to 17 bits
    endfunction

    task automatic pushNops(int n);
        repeat (n) prog.push_back(32'd0);
    endtask

    task automatic checkValue(string name, logic [31:0] got, logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("[FAIL] %s: got 0x%08h expected 0x%08h", name, got, expected);
        end
    endtask

    task automatic writeModel(logic [4:0] rd, logic [31:0] value);
        if (rd != 5'd0) begin // r0 writes vanish
            modelRegs[rd] = value;
            expWbAddr.push_back({27'd0, rd});
            expWbData.push_back(value);
        end
    endtask

    // Sequential execution of the program, one instruction at a time
    task automatic runModel();
        logic [31:0] ir, a, b, imm, res, addr;
        logic [4:0] op, rd, rs, rt, sh, fn;
        for (int r = 0; r < 32; r++) modelRegs[r] = '0;
        expWbAddr.delete();
        expWbData.delete();
        expStAddr.delete();
        expStData.delete();
        foreach (prog[i]) begin
            ir  = prog[i];
            op  = ir[31:27];
            rd  = ir[26:22];
            rs  = ir[21:17];
            rt  = ir[16:12];
            sh  = ir[11:7];
            fn  = ir[6:2];
            imm = {{15{ir[16]}}, ir[16:0]};
            a   = modelRegs[rs];
            b   = modelRegs[rt];
            addr = a + imm;
            if (op == procPkg::OP_RTYPE) begin
                case (fn)
                    procPkg::ALU_ADD: res = a + b;
                    procPkg::ALU_SUB: res = a - b;
                    procPkg::ALU_AND: res = a & b;
                    procPkg::ALU_OR:  res = a | b;
                    procPkg::ALU_SLL: res = a << sh;
                    procPkg::ALU_SRA: res = $signed(a) >>> sh;
                    default:          res = '0;
                endcase
                writeModel(rd, res);
            end else if (op == procPkg::OP_ADDI) begin
                writeModel(rd, addr);
            end else if (op == procPkg::OP_LW) begin
                writeModel(rd, modelMem[addr[MEM_LOG2-1:0]]);
            end else if (op == procPkg::OP_SW) begin
                expStAddr.push_back(addr);
                expStData.push_back(modelRegs[rd]);
                modelMem[addr[MEM_LOG2-1:0]] = modelRegs[rd];
            end
        end
    endtask

    // Load under reset, run until the expected streams arrive, compare
    task automatic runProgram(string name);
        int errorsBefore;
        int limit;
        int cycles;
        errorsBefore = errors;
        testsRun++;
        runModel();
        @(negedge clock);
        reset = 1'b1;
        for (int i = 0; i < prog.size() + TAIL_NOPS; i++) begin
            progWrite = 1'b1;
            progAddr  = i;
            progData  = (i < prog.size()) ? prog[i] : 32'd0;
            @(negedge clock);
        end
        progWrite = 1'b0;
        obsWbAddr.delete(); // Pipeline is cleared by now
        obsWbData.delete();
        obsStAddr.delete();
        obsStData.delete();
        reset = 1'b0;
        limit  = 4 * prog.size() + 40;
        cycles = 0;
        while ((obsWbAddr.size() < expWbAddr.size() || obsStAddr.size() < expStAddr.size())
               && cycles < limit) begin
            @(negedge clock);
            cycles++;
        end
        repeat (3) @(negedge clock); // Room for stray writebacks
        if (obsWbAddr.size() < expWbAddr.size() || obsStAddr.size() < expStAddr.size()) begin
            $display("%s: gave up waiting for writebacks or stores after %0d cycles",
                     name, cycles);
        end
        checkValue("writeback count", obsWbAddr.size(), expWbAddr.size());
        checkValue("store count", obsStAddr.size(), expStAddr.size());
        for (int i = 0; i < obsWbAddr.size() && i < expWbAddr.size(); i++) begin
            checkValue($sformatf("regWriteAddr[%0d]", i), obsWbAddr[i], expWbAddr[i]);
            checkValue($sformatf("regWriteData[%0d]", i), obsWbData[i], expWbData[i]);
        end
        for (int i = 0; i < obsStAddr.size() && i < expStAddr.size(); i++) begin
            checkValue($sformatf("memAddr[%0d]", i), obsStAddr[i], expStAddr[i]);
            checkValue($sformatf("memData[%0d]", i), obsStData[i], expStData[i]);
        end
        if (errors == errorsBefore) $display("Test %0d %s: ok", testsRun, name);
        else $display("Test %0d %s: %0d errors", testsRun, name, errors - errorsBefore);
    endtask

    task automatic testIndependentAlu();
        prog.delete();
        prog.push_back(encodeI(procPkg::OP_ADDI, 1, 0, 'h1F0F));
        prog.push_back(encodeI(procPkg::OP_ADDI, 2, 0, 'h0123));
        prog.push_back(encodeI(procPkg::OP_ADDI, 9, 0, -300)); // Negative for sra
        pushNops(3);
        prog.push_back(encodeR(procPkg::ALU_ADD, 3, 1, 2, 0));
        pushNops(3);
        prog.push_back(encodeR(procPkg::ALU_SUB, 4, 1, 2, 0));
        pushNops(3);
        prog.push_back(encodeR(procPkg::ALU_AND, 5, 1, 2, 0));
        pushNops(3);
        prog.push_back(encodeR(procPkg::ALU_OR, 6, 1, 2, 0));
        pushNops(3);
        prog.push_back(encodeR(procPkg::ALU_SLL, 7, 1, 0, 4));
        pushNops(3);
        prog.push_back(encodeR(procPkg::ALU_SRA, 8, 9, 0, 3));
        pushNops(3);
        runProgram("independent ALU ops");
    endtask

    task automatic testDependentChains();
        prog.delete();
        prog.push_back(encodeI(procPkg::OP_ADDI, 1, 0, 5));
        prog.push_back(encodeR(procPkg::ALU_ADD, 2, 1, 1, 0)); // Distance one
        prog.push_back(encodeR(procPkg::ALU_SUB, 3, 2, 1, 0)); // One and two
        pushNops(1);
        prog.push_back(encodeR(procPkg::ALU_OR, 4, 3, 2, 0));  // Two and three
        pushNops(2);
        prog.push_back(encodeR(procPkg::ALU_AND, 5, 4, 3, 0)); // Through the register file
        prog.push_back(encodeR(procPkg::ALU_SLL, 6, 5, 0, 2));
        prog.push_back(encodeR(procPkg::ALU_ADD, 7, 6, 6, 0));
        prog.push_back(encodeI(procPkg::OP_ADDI, 7, 7, -1));   // Same rd again
        runProgram("dependent chains");
    endtask

    task automatic testImmediates();
        prog.delete();
        prog.push_back(encodeI(procPkg::OP_ADDI, 1, 0, -1));
        prog.push_back(encodeI(procPkg::OP_ADDI, 2, 0, -65536)); // Most negative
        prog.push_back(encodeI(procPkg::OP_ADDI, 3, 1, -2));
        prog.push_back(encodeI(procPkg::OP_ADDI, 4, 0, 65535));
        prog.push_back(encodeR(procPkg::ALU_ADD, 5, 4, 2, 0));
        prog.push_back(encodeR(procPkg::ALU_SRA, 6, 2, 0, 8));
        runProgram("negative immediates");
    endtask

    task automatic testLoadStore();
        prog.delete();
        prog.push_back(encodeI(procPkg::OP_ADDI, 1, 0, 100));
        prog.push_back(encodeI(procPkg::OP_ADDI, 2, 0, 'h1234));
        prog.push_back(encodeI(procPkg::OP_SW, 2, 1, 3));  // Store data forwarded
        prog.push_back(encodeI(procPkg::OP_SW, 1, 1, -1));
        prog.push_back(encodeI(procPkg::OP_LW, 3, 1, 3));
        prog.push_back(encodeR(procPkg::ALU_ADD, 4, 3, 2, 0)); // Load-use bubble
        prog.push_back(encodeI(procPkg::OP_LW, 5, 1, -1));
        prog.push_back(encodeI(procPkg::OP_SW, 5, 0, 0));  // Load-use on store data
        prog.push_back(encodeI(procPkg::OP_LW, 6, 0, 0));
        runProgram("stores and loads");
    endtask

    task automatic testZeroRegister();
        prog.delete();
        prog.push_back(encodeI(procPkg::OP_ADDI, 1, 0, 9));
        prog.push_back(encodeI(procPkg::OP_ADDI, 0, 0, 77));
        prog.push_back(encodeR(procPkg::ALU_ADD, 0, 1, 1, 0));
        prog.push_back(encodeR(procPkg::ALU_ADD, 2, 0, 1, 0)); // r0 must not forward
        prog.push_back(encodeI(procPkg::OP_LW, 0, 0, 0));
        prog.push_back(encodeR(procPkg::ALU_SUB, 3, 0, 1, 0));
        runProgram("writes to r0");
    endtask

    task automatic testRandomProgram();
        logic [31:0] kind, rd, rs, rt, sh, op, imm;
        prog.delete();
        for (int i = 0; i < RANDOM_LEN; i++) begin
            kind = randBits(2);
            rd   = randBits(3); // r0..r7 keeps dependencies dense
            rs   = randBits(3);
            rt   = randBits(3);
            if (kind == 0) begin
                imm = randBits(17);
                prog.push_back(encodeI(procPkg::OP_ADDI, rd, rs, imm));
            end else begin
                op = randBits(3);
                if (op > 5) op = op - 6; // Only the six defined ops
                sh = randBits(5);
                prog.push_back(encodeR(op, rd, rs, rt, sh));
            end
        end
        runProgram("random program");
    endtask

    initial begin
        clock     = 1'b0;
        reset     = 1'b1;
        progWrite = 1'b0;
        progAddr  = '0;
        progData  = '0;
        for (int i = 0; i < 2**MEM_LOG2; i++) modelMem[i] = '0;
        testIndependentAlu();
        testDependentChains();
        testImmediates();
        testLoadStore();
        testZeroRegister();
        testRandomProgram();
        $display("Tests %0d, checks %0d, errors %0d", testsRun, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
src/procPkg.sv
src/instrMem.sv
src/fetchStage.sv
src/regFile.sv
src/hazardUnit.sv
src/decodeExecute.sv
src/dataMem.sv
src/memWriteback.sv
src/procTop.sv
dv/procTb.sv

//--- Makefile
SOURCES := $(wildcard src/*.sv dv/*.sv)

.PHONY: all lint clean

all: obj_dir/VprocTb
	./obj_dir/VprocTb | tee sim.log
	grep -q "Simulation PASSED" sim.log

obj_dir/VprocTb: filelist.f $(SOURCES)
	verilator --binary --timing -j 0 -f filelist.f --top-module procTb

lint:
	verilator --lint-only --timing -f filelist.f --top-module procTb

clean:
	rm -rf obj_dir sim.log
